// File: source/mipsControlPkg.sv
// ========================================
// field, selector and exception types for
// the single-cycle MIPS control unit
// opcode and function values follow MIPS32
// no floating-point unit, so COP1 is absent
// ========================================

package mipsControlPkg;

	typedef logic [5:0] opcodeT;
	typedef logic [5:0] functT;
	typedef logic [4:0] fmtT;
	typedef logic [1:0] regDstT;
	typedef logic [1:0] aluSrcT;
	typedef logic [2:0] memToRegT;
	typedef logic [2:0] pcSrcT;
	typedef logic [1:0] aluOpT;
	typedef logic [4:0] excCodeT;
	typedef logic [4:0] instrClassT;

	localparam opcodeT opRFmt = 6'h00;
	localparam opcodeT opJ = 6'h02;
	localparam opcodeT opJal = 6'h03;
	localparam opcodeT opBeq = 6'h04;
	localparam opcodeT opBne = 6'h05;
	localparam opcodeT opAddi = 6'h08;
	localparam opcodeT opAddiu = 6'h09;
	localparam opcodeT opSlti = 6'h0a;
	localparam opcodeT opSltiu = 6'h0b;
	localparam opcodeT opAndi = 6'h0c;
	localparam opcodeT opOri = 6'h0d;
	localparam opcodeT opXori = 6'h0e;
	localparam opcodeT opLui = 6'h0f;
	localparam opcodeT opCop0 = 6'h10;
	localparam opcodeT opLb = 6'h20;
	localparam opcodeT opLh = 6'h21;
	localparam opcodeT opLw = 6'h23;
	localparam opcodeT opLbu = 6'h24;
	localparam opcodeT opLhu = 6'h25;
	localparam opcodeT opSb = 6'h28;
	localparam opcodeT opSh = 6'h29;
	localparam opcodeT opSw = 6'h2b;

	localparam functT funSll = 6'h00;
	localparam functT funSrl = 6'h02;
	localparam functT funSra = 6'h03;
	localparam functT funSllv = 6'h04;
	localparam functT funSrlv = 6'h06;
	localparam functT funSrav = 6'h07;
	localparam functT funJr = 6'h08;
	localparam functT funMovz = 6'h0a;
	localparam functT funMovn = 6'h0b;
	localparam functT funSyscall = 6'h0c;
	localparam functT funMfhi = 6'h10;
	localparam functT funMthi = 6'h11;
	localparam functT funMflo = 6'h12;
	localparam functT funMtlo = 6'h13;
	localparam functT funMult = 6'h18;
	localparam functT funMultu = 6'h19;
	localparam functT funDiv = 6'h1a;
	localparam functT funDivu = 6'h1b;
	localparam functT funAdd = 6'h20;
	localparam functT funAddu = 6'h21;
	localparam functT funSub = 6'h22;
	localparam functT funSubu = 6'h23;
	localparam functT funAnd = 6'h24;
	localparam functT funOr = 6'h25;
	localparam functT funXor = 6'h26;
	localparam functT funNor = 6'h27;
	localparam functT funSlt = 6'h2a;
	localparam functT funSltu = 6'h2b;
	// only meaningful under the COP0 eret format
	localparam functT funEret = 6'h18;

	localparam fmtT fmtMfc = 5'h00;
	localparam fmtT fmtMtc = 5'h04;
	localparam fmtT fmtEret = 5'h10;

	localparam regDstT regDstRt = 2'd0;
	localparam regDstT regDstRd = 2'd1;
	localparam regDstT regDstRa = 2'd2;

	localparam aluSrcT aluSrcReg = 2'd0;
	localparam aluSrcT aluSrcSignImm = 2'd1;
	localparam aluSrcT aluSrcZeroImm = 2'd2;

	// codes 1 and 4 are unused without the FPU
	localparam memToRegT wbAlu = 3'd0;
	localparam memToRegT wbLink = 3'd2;
	localparam memToRegT wbUpperImm = 3'd3;
	localparam memToRegT wbCop0 = 3'd5;
	localparam memToRegT wbMemory = 3'd6;
	localparam memToRegT wbMoveSrc = 3'd7;

	localparam pcSrcT pcSeq = 3'd0;
	localparam pcSrcT pcBeq = 3'd1;
	localparam pcSrcT pcJump = 3'd2;
	localparam pcSrcT pcReg = 3'd3;
	localparam pcSrcT pcVector = 3'd4;
	localparam pcSrcT pcBne = 3'd5;

	localparam aluOpT aluAdd = 2'd0;
	localparam aluOpT aluSub = 2'd1;
	localparam aluOpT aluFunct = 2'd2;
	localparam aluOpT aluImm = 2'd3;

	localparam excCodeT excInterrupt = 5'd0;
	localparam excCodeT excSyscall = 5'd8;
	localparam excCodeT excReserved = 5'd10;
	localparam excCodeT excOverflow = 5'd12;

	// clsInvalid must stay the highest code
	localparam instrClassT clsStore = 5'd0;
	localparam instrClassT clsLoad = 5'd1;
	localparam instrClassT clsBeq = 5'd2;
	localparam instrClassT clsBne = 5'd3;
	localparam instrClassT clsJump = 5'd4;
	localparam instrClassT clsJal = 5'd5;
	localparam instrClassT clsJr = 5'd6;
	localparam instrClassT clsSyscall = 5'd7;
	localparam instrClassT clsAddSub = 5'd8;
	localparam instrClassT clsRType = 5'd9;
	localparam instrClassT clsMovz = 5'd10;
	localparam instrClassT clsMovn = 5'd11;
	localparam instrClassT clsAddi = 5'd12;
	localparam instrClassT clsImmArith = 5'd13;
	localparam instrClassT clsImmLogic = 5'd14;
	localparam instrClassT clsLui = 5'd15;
	localparam instrClassT clsMfc0 = 5'd16;
	localparam instrClassT clsMtc0 = 5'd17;
	localparam instrClassT clsEret = 5'd18;
	localparam instrClassT clsInvalid = 5'd19;

endpackage

// File: source/instrDecoder.sv
// ========================================
// purely combinational instruction decode
// iCLK and rstN only sample the assertion
// unlisted opcodes, functions and formats
// all decode to clsInvalid
// ========================================
`timescale 1ns/1ps

module instrDecoder
	import mipsControlPkg::*;
(
	input logic iCLK,
	input logic rstN,
	input opcodeT op,
	input functT funct,
	input fmtT fmt,
	output instrClassT instrClass
);

	always_comb
	begin
		instrClass = clsInvalid;
		case (op)
			opSw, opSh, opSb:
				instrClass = clsStore;
			opLw, opLh, opLb, opLhu, opLbu:
				instrClass = clsLoad;
			opBeq:
				instrClass = clsBeq;
			opBne:
				instrClass = clsBne;
			opJ:
				instrClass = clsJump;
			opJal:
				instrClass = clsJal;
			opAddi:
				instrClass = clsAddi;
			opAddiu, opSlti, opSltiu:
				instrClass = clsImmArith;
			opAndi, opOri, opXori:
				instrClass = clsImmLogic;
			opLui:
				instrClass = clsLui;
			opRFmt:
			begin
				case (funct)
					funJr:
						instrClass = clsJr;
					funSyscall:
						instrClass = clsSyscall;
					funAdd, funSub:
						instrClass = clsAddSub;
					funMovz:
						instrClass = clsMovz;
					funMovn:
						instrClass = clsMovn;
					funSll, funSrl, funSra, funSllv, funSrlv, funSrav,
					funMfhi, funMthi, funMflo, funMtlo,
					funMult, funMultu, funDiv, funDivu,
					funAddu, funSubu, funAnd, funOr, funXor, funNor,
					funSlt, funSltu:
						instrClass = clsRType;
					default:
						instrClass = clsInvalid;
				endcase
			end
			opCop0:
			begin
				case (fmt)
					fmtMfc:
						instrClass = clsMfc0;
					fmtMtc:
						instrClass = clsMtc0;
					// eret format needs the eret function too
					fmtEret:
						instrClass = (funct == funEret) ? clsEret : clsInvalid;
					default:
						instrClass = clsInvalid;
				endcase
			end
			default:
				instrClass = clsInvalid;
		endcase
	end

	// I and J formats decode from the opcode alone
	opcodeOnly: assert property (@(posedge iCLK) disable iff (!rstN)
		(op != opRFmt && op != opCop0 && $stable(op)) |-> $stable(instrClass));

endmodule

// File: source/datapathControl.sv
// ========================================
// class to datapath control word
// combinational, zero cycles of latency
// equalZero only matters for movz and movn
// ========================================
`timescale 1ns/1ps

module datapathControl
	import mipsControlPkg::*;
(
	input logic iCLK,
	input logic rstN,
	input instrClassT instrClass,
	input logic equalZero,
	output regDstT regDst,
	output aluSrcT aluSrc,
	output memToRegT memToReg,
	output pcSrcT pcSrc,
	output aluOpT aluOp,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output logic branchDelay
);

	always_comb
	begin
		// mtc0 and invalid keep this all-zero word
		regDst = regDstRt;
		aluSrc = aluSrcReg;
		memToReg = wbAlu;
		pcSrc = pcSeq;
		aluOp = aluAdd;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		branchDelay = 1'b0;
		case (instrClass)
			clsStore:
			begin
				aluSrc = aluSrcSignImm;
				memWrite = 1'b1;
			end
			clsLoad:
			begin
				aluSrc = aluSrcSignImm;
				memToReg = wbMemory;
				regWrite = 1'b1;
				memRead = 1'b1;
			end
			clsBeq, clsBne:
			begin
				aluOp = aluSub;
				pcSrc = (instrClass == clsBeq) ? pcBeq : pcBne;
				branchDelay = 1'b1;
			end
			clsJump, clsJal:
			begin
				pcSrc = pcJump;
				branchDelay = 1'b1;
				regDst = (instrClass == clsJal) ? regDstRa : regDstRd;
				memToReg = (instrClass == clsJal) ? wbLink : wbAlu;
				regWrite = (instrClass == clsJal);
			end
			clsJr:
			begin
				pcSrc = pcReg;
				branchDelay = 1'b1;
			end
			clsSyscall, clsEret:
				pcSrc = pcVector;
			clsAddSub, clsRType:
			begin
				regDst = regDstRd;
				aluOp = aluFunct;
				regWrite = 1'b1;
			end
			clsMovz, clsMovn:
			begin
				regDst = regDstRd;
				memToReg = wbMoveSrc;
				aluOp = (instrClass == clsMovn) ? aluSub : aluAdd;
				// movz writes on a zero rt, movn on a nonzero one
				regWrite = (instrClass == clsMovz) ? equalZero : !equalZero;
			end
			clsAddi, clsImmArith, clsImmLogic:
			begin
				aluSrc = (instrClass == clsImmLogic) ? aluSrcZeroImm : aluSrcSignImm;
				aluOp = aluImm;
				regWrite = 1'b1;
			end
			clsLui:
			begin
				memToReg = wbUpperImm;
				regWrite = 1'b1;
			end
			clsMfc0:
			begin
				memToReg = wbCop0;
				regWrite = 1'b1;
			end
			default:
				regWrite = 1'b0;
		endcase
	end

	memExclusive: assert property (@(posedge iCLK) disable iff (!rstN)
		!(memRead && memWrite));

endmodule

// File: source/exceptionControl.sv
// ========================================
// COP0 exception and privilege decision
// excLevel masks everything but the COP0
// privilege trap, which userMode raises
// NumInterrupts sets the pending width
// ========================================
`timescale 1ns/1ps

module exceptionControl
	import mipsControlPkg::*;
#(
	parameter int NumInterrupts = 8
)
(
	input logic iCLK,
	input logic rstN,
	input instrClassT instrClass,
	input logic aluOverflow,
	input logic excLevel,
	input logic userMode,
	input logic [NumInterrupts-1:0] pendingInterrupt,
	output logic excOccurred,
	output excCodeT excCode,
	output logic cop0Write,
	output logic eret
);

	logic intPending;
	logic cop0Class;

	assign intPending = |pendingInterrupt;
	assign cop0Class = (instrClass == clsMfc0) || (instrClass == clsMtc0) ||
		(instrClass == clsEret);

	always_comb
	begin
		excOccurred = intPending && !excLevel;
		excCode = excInterrupt;
		case (instrClass)
			// trapping arithmetic, overflow wins over an interrupt
			clsAddSub, clsAddi, clsMovz, clsMovn:
			begin
				excOccurred = (aluOverflow || intPending) && !excLevel;
				excCode = aluOverflow ? excOverflow : excInterrupt;
			end
			clsSyscall:
			begin
				excOccurred = !excLevel;
				excCode = excSyscall;
			end
			clsInvalid:
			begin
				excOccurred = !excLevel;
				excCode = excReserved;
			end
			clsMfc0, clsMtc0, clsEret:
			begin
				excOccurred = userMode;
				excCode = excReserved;
			end
			default:
				excCode = excInterrupt;
		endcase
	end

	// privileged side effects only in kernel mode
	assign cop0Write = (instrClass == clsMtc0) && !userMode;
	assign eret = (instrClass == clsEret) && !userMode;

	levelMasks: assert property (@(posedge iCLK) disable iff (!rstN)
		(excLevel && !cop0Class) |-> !excOccurred);

endmodule

// File: source/mipsControl.sv
// ========================================
// single-cycle MIPS main control, no FPU
// all outputs are combinational
// iCLK and rstN only clock the assertions
// ========================================
`timescale 1ns/1ps

module mipsControl
	import mipsControlPkg::*;
#(
	parameter int NumInterrupts = 8
)
(
	input logic iCLK,
	input logic rstN,
	input opcodeT op,
	input functT funct,
	input fmtT fmt,
	input logic equalZero,
	input logic aluOverflow,
	input logic excLevel,
	input logic userMode,
	input logic [NumInterrupts-1:0] pendingInterrupt,
	output regDstT regDst,
	output aluSrcT aluSrc,
	output memToRegT memToReg,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output pcSrcT pcSrc,
	output aluOpT aluOp,
	output logic branchDelay,
	output logic excOccurred,
	output excCodeT excCode,
	output logic cop0Write,
	output logic eret
);

	instrClassT instrClass;

	instrDecoder instrDecoder_i (
		.iCLK(iCLK),
		.rstN(rstN),
		.op(op),
		.funct(funct),
		.fmt(fmt),
		.instrClass(instrClass)
	);

	datapathControl datapathControl_i (
		.iCLK(iCLK),
		.rstN(rstN),
		.instrClass(instrClass),
		.equalZero(equalZero),
		.regDst(regDst),
		.aluSrc(aluSrc),
		.memToReg(memToReg),
		.pcSrc(pcSrc),
		.aluOp(aluOp),
		.regWrite(regWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.branchDelay(branchDelay)
	);

	exceptionControl #(
		.NumInterrupts(NumInterrupts)
	) exceptionControl_i (
		.iCLK(iCLK),
		.rstN(rstN),
		.instrClass(instrClass),
		.aluOverflow(aluOverflow),
		.excLevel(excLevel),
		.userMode(userMode),
		.pendingInterrupt(pendingInterrupt),
		.excOccurred(excOccurred),
		.excCode(excCode),
		.cop0Write(cop0Write),
		.eret(eret)
	);

endmodule

// File: testbench/controlChecker.sv
// ========================================
// watches the control unit ports and
// compares each rising edge after reset
// expected values come from the decode
// rules, worked out from the raw fields
// ========================================
`timescale 1ns/1ps

module controlChecker
	import mipsControlPkg::*;
#(
	parameter int NumInterrupts = 8
)
(
	input logic iCLK,
	input logic rstN,
	input opcodeT op,
	input functT funct,
	input fmtT fmt,
	input logic equalZero,
	input logic aluOverflow,
	input logic excLevel,
	input logic userMode,
	input logic [NumInterrupts-1:0] pendingInterrupt,
	input regDstT regDst,
	input aluSrcT aluSrc,
	input memToRegT memToReg,
	input logic regWrite,
	input logic memRead,
	input logic memWrite,
	input pcSrcT pcSrc,
	input aluOpT aluOp,
	input logic branchDelay,
	input logic excOccurred,
	input excCodeT excCode,
	input logic cop0Write,
	input logic eret,
	output int errorCount,
	output int checkCount
);

	typedef struct packed {
		regDstT regDst;
		aluSrcT aluSrc;
		memToRegT memToReg;
		logic regWrite;
		logic memRead;
		logic memWrite;
		pcSrcT pcSrc;
		aluOpT aluOp;
		logic branchDelay;
		logic excOccurred;
		excCodeT excCode;
		logic cop0Write;
		logic eret;
	} ctrlWordT;

	ctrlWordT expWord;

	function automatic ctrlWordT expectedControl(input opcodeT o, input functT f, input fmtT m,
		input logic ez, input logic ovf, input logic lvl, input logic usr, input logic intOn);
		ctrlWordT w;
		logic trapping;
		logic privileged;
		logic reserved;
		logic syscallHit;
		w = '0;
		trapping = 1'b0;
		privileged = 1'b0;
		reserved = 1'b0;
		syscallHit = 1'b0;
		case (o)
			opSb, opSh, opSw:
			begin
				w.aluSrc = aluSrcSignImm;
				w.memWrite = 1'b1;
			end
			opLb, opLh, opLw, opLbu, opLhu:
			begin
				w.aluSrc = aluSrcSignImm;
				w.memToReg = wbMemory;
				w.regWrite = 1'b1;
				w.memRead = 1'b1;
			end
			opBeq, opBne:
			begin
				w.aluOp = aluSub;
				w.pcSrc = (o == opBeq) ? pcBeq : pcBne;
				w.branchDelay = 1'b1;
			end
			opJ:
			begin
				w.regDst = regDstRd;
				w.pcSrc = pcJump;
				w.branchDelay = 1'b1;
			end
			opJal:
			begin
				w.regDst = regDstRa;
				w.memToReg = wbLink;
				w.pcSrc = pcJump;
				w.regWrite = 1'b1;
				w.branchDelay = 1'b1;
			end
			opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori:
			begin
				w.aluSrc = (o >= opAndi) ? aluSrcZeroImm : aluSrcSignImm;
				w.aluOp = aluImm;
				w.regWrite = 1'b1;
				trapping = (o == opAddi);
			end
			opLui:
			begin
				w.memToReg = wbUpperImm;
				w.regWrite = 1'b1;
			end
			opCop0:
			begin
				privileged = 1'b1;
				if (m == fmtMfc)
				begin
					w.memToReg = wbCop0;
					w.regWrite = 1'b1;
				end
				else if (m == fmtEret && f == funEret)
				begin
					w.pcSrc = pcVector;
					w.eret = !usr;
				end
				else if (m == fmtMtc)
					w.cop0Write = !usr;
				else
				begin
					privileged = 1'b0;
					reserved = 1'b1;
				end
			end
			opRFmt:
			begin
				case (f)
					funJr:
					begin
						w.pcSrc = pcReg;
						w.branchDelay = 1'b1;
					end
					funSyscall:
					begin
						w.pcSrc = pcVector;
						syscallHit = 1'b1;
					end
					funMovz, funMovn:
					begin
						w.regDst = regDstRd;
						w.memToReg = wbMoveSrc;
						w.aluOp = (f == funMovz) ? aluAdd : aluSub;
						w.regWrite = (f == funMovz) ? ez : !ez;
						trapping = 1'b1;
					end
					funAdd, funSub, funSll, funSrl, funSra, funSllv, funSrlv, funSrav,
					funMfhi, funMthi, funMflo, funMtlo, funMult, funMultu, funDiv,
					funDivu, funAddu, funSubu, funAnd, funOr, funXor, funNor, funSlt,
					funSltu:
					begin
						w.regDst = regDstRd;
						w.aluOp = aluFunct;
						w.regWrite = 1'b1;
						trapping = (f == funAdd) || (f == funSub);
					end
					default:
						reserved = 1'b1;
				endcase
			end
			default:
				reserved = 1'b1;
		endcase
		// COP0 privilege trap ignores excLevel
		if (privileged)
			w.excOccurred = usr;
		else if (reserved || syscallHit)
			w.excOccurred = !lvl;
		else if (trapping)
			w.excOccurred = (ovf || intOn) && !lvl;
		else
			w.excOccurred = intOn && !lvl;
		if (privileged || reserved)
			w.excCode = excReserved;
		else if (syscallHit)
			w.excCode = excSyscall;
		else if (trapping && ovf)
			w.excCode = excOverflow;
		else
			w.excCode = excInterrupt;
		return w;
	endfunction

	task automatic checkField(input string name, input logic [7:0] expV, input logic [7:0] actV);
		if (actV !== expV)
		begin
			errorCount++;
			$display("Mismatch %s: expected 0x%h, actual 0x%h (op 0x%h funct 0x%h fmt 0x%h)",
				name, expV, actV, op, funct, fmt);
		end
	endtask

	always @(posedge iCLK)
	begin
		if (!rstN)
		begin
			errorCount = 0;
			checkCount = 0;
		end
		else
		begin
			expWord = expectedControl(op, funct, fmt, equalZero, aluOverflow, excLevel,
				userMode, |pendingInterrupt);
			checkCount++;
			checkField("regDst", 8'(expWord.regDst), 8'(regDst));
			checkField("aluSrc", 8'(expWord.aluSrc), 8'(aluSrc));
			checkField("memToReg", 8'(expWord.memToReg), 8'(memToReg));
			checkField("regWrite", 8'(expWord.regWrite), 8'(regWrite));
			checkField("memRead", 8'(expWord.memRead), 8'(memRead));
			checkField("memWrite", 8'(expWord.memWrite), 8'(memWrite));
			checkField("pcSrc", 8'(expWord.pcSrc), 8'(pcSrc));
			checkField("aluOp", 8'(expWord.aluOp), 8'(aluOp));
			checkField("branchDelay", 8'(expWord.branchDelay), 8'(branchDelay));
			checkField("excOccurred", 8'(expWord.excOccurred), 8'(excOccurred));
			checkField("excCode", 8'(expWord.excCode), 8'(excCode));
			checkField("cop0Write", 8'(expWord.cop0Write), 8'(cop0Write));
			checkField("eret", 8'(expWord.eret), 8'(eret));
		end
	end

endmodule

// File: testbench/mipsControlTb.sv
// ========================================
// drives the control unit on falling edges
// checking happens in controlChecker
// status nibble is {equalZero, overflow,
// excLevel, userMode}
// ========================================
`timescale 1ns/1ps

module mipsControlTb
	import mipsControlPkg::*;
();

	localparam int NumInterrupts = 8;
	localparam int ClockPeriod = 20;
	localparam int ResetCycles = 10;
	localparam int RandomVectors = 2000;
	// upper bound on the directed vectors
	localparam int DirectedVectors = 200;
	localparam int WatchdogTime = 2 * (DirectedVectors + RandomVectors) * ClockPeriod
		+ ResetCycles * ClockPeriod;

	localparam logic [3:0] stNone = 4'b0000;
	localparam logic [3:0] stEz = 4'b1000;
	localparam logic [3:0] stOvf = 4'b0100;
	localparam logic [3:0] stLvl = 4'b0010;
	localparam logic [3:0] stUser = 4'b0001;
	localparam logic [NumInterrupts-1:0] noInt = '0;
	localparam logic [NumInterrupts-1:0] oneInt = NumInterrupts'(1) << (NumInterrupts - 1);

	logic iCLK;
	logic rstN;
	opcodeT op;
	functT funct;
	fmtT fmt;
	logic equalZero;
	logic aluOverflow;
	logic excLevel;
	logic userMode;
	logic [NumInterrupts-1:0] pendingInterrupt;
	regDstT regDst;
	aluSrcT aluSrc;
	memToRegT memToReg;
	logic regWrite;
	logic memRead;
	logic memWrite;
	pcSrcT pcSrc;
	aluOpT aluOp;
	logic branchDelay;
	logic excOccurred;
	excCodeT excCode;
	logic cop0Write;
	logic eret;
	int errorCount;
	int checkCount;
	int errorsBefore;
	int testCount;
	int seed;
	int r;
	int s;

	opcodeT memOps [8] = '{opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw};
	opcodeT unknownOps [4] = '{6'h01, 6'h06, 6'h11, 6'h3f};
	opcodeT keptOps [16] = '{opRFmt, opJ, opJal, opBeq, opBne, opAddi, opAddiu, opSlti,
		opSltiu, opAndi, opOri, opXori, opLui, opCop0, opLw, opSw};
	fmtT fmtPicks [4] = '{fmtMfc, fmtMtc, fmtEret, 5'h1f};
	logic [3:0] trapSt [5] = '{stOvf, stOvf | stLvl, stNone, stLvl, stOvf};
	logic [NumInterrupts-1:0] trapPend [5] = '{noInt, noInt, oneInt, oneInt, oneInt};

	mipsControl #(
		.NumInterrupts(NumInterrupts)
	) mipsControl_i (
		.iCLK(iCLK),
		.rstN(rstN),
		.op(op),
		.funct(funct),
		.fmt(fmt),
		.equalZero(equalZero),
		.aluOverflow(aluOverflow),
		.excLevel(excLevel),
		.userMode(userMode),
		.pendingInterrupt(pendingInterrupt),
		.regDst(regDst),
		.aluSrc(aluSrc),
		.memToReg(memToReg),
		.regWrite(regWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.pcSrc(pcSrc),
		.aluOp(aluOp),
		.branchDelay(branchDelay),
		.excOccurred(excOccurred),
		.excCode(excCode),
		.cop0Write(cop0Write),
		.eret(eret)
	);

	controlChecker #(
		.NumInterrupts(NumInterrupts)
	) controlChecker_i (
		.iCLK(iCLK),
		.rstN(rstN),
		.op(op),
		.funct(funct),
		.fmt(fmt),
		.equalZero(equalZero),
		.aluOverflow(aluOverflow),
		.excLevel(excLevel),
		.userMode(userMode),
		.pendingInterrupt(pendingInterrupt),
		.regDst(regDst),
		.aluSrc(aluSrc),
		.memToReg(memToReg),
		.regWrite(regWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.pcSrc(pcSrc),
		.aluOp(aluOp),
		.branchDelay(branchDelay),
		.excOccurred(excOccurred),
		.excCode(excCode),
		.cop0Write(cop0Write),
		.eret(eret),
		.errorCount(errorCount),
		.checkCount(checkCount)
	);

	always #(ClockPeriod / 2) iCLK = ~iCLK;

	task automatic applyVector(input opcodeT o, input fmtT m, input functT f,
		input logic [3:0] st, input logic [NumInterrupts-1:0] pend);
		@(negedge iCLK);
		op = o;
		fmt = m;
		funct = f;
		{equalZero, aluOverflow, excLevel, userMode} = st;
		pendingInterrupt = pend;
	endtask

	// last vector was compared on the rising edge before this one
	task automatic finishTest(input string name);
		@(negedge iCLK);
		testCount++;
		$display("test %0d (%s) finished with %0d errors", testCount, name,
			errorCount - errorsBefore);
		errorsBefore = errorCount;
	endtask

	initial
	begin
		#(WatchdogTime);
		$display("timeout: the run did not finish within %0d ns", WatchdogTime);
		$display("tests failed");
		$finish;
	end

	initial
	begin
		seed = 32'h3b85_7069;
		iCLK = 1'b0;
		rstN = 1'b0;
		op = opRFmt;
		funct = funSll;
		fmt = fmtMfc;
		equalZero = 1'b0;
		aluOverflow = 1'b0;
		excLevel = 1'b0;
		userMode = 1'b0;
		pendingInterrupt = noInt;
		errorsBefore = 0;
		testCount = 0;
		repeat (ResetCycles) @(posedge iCLK);
		@(negedge iCLK);
		rstN = 1'b1;

		for (int i = 0; i < 8; i++)
		begin
			applyVector(memOps[i], fmtMfc, funSll, stNone, noInt);
			applyVector(memOps[i], fmtMfc, funSll, stLvl, oneInt);
		end
		finishTest("loads and stores");

		for (int i = 0; i < 2; i++)
		begin
			applyVector(opBeq, fmtMfc, funSll, stNone, (i == 1) ? oneInt : noInt);
			applyVector(opBne, fmtMfc, funSll, stNone, (i == 1) ? oneInt : noInt);
			applyVector(opJ, fmtMfc, funSll, stNone, (i == 1) ? oneInt : noInt);
			applyVector(opJal, fmtMfc, funSll, stNone, (i == 1) ? oneInt : noInt);
			applyVector(opRFmt, fmtMfc, funJr, stNone, (i == 1) ? oneInt : noInt);
		end
		finishTest("branches and jumps");

		// every function code, known and unknown
		for (int f = 0; f < 64; f++)
			applyVector(opRFmt, fmtMfc, functT'(f), f[0] ? stEz : stNone, noInt);
		applyVector(opRFmt, fmtMfc, funMovz, stEz, noInt);
		applyVector(opRFmt, fmtMfc, funMovn, stNone, noInt);
		for (int o = 8; o < 16; o++)
			applyVector(opcodeT'(o), fmtMfc, funSll, stNone, noInt);
		for (int i = 0; i < 4; i++)
		begin
			applyVector(unknownOps[i], fmtMfc, funSll, stNone, noInt);
			applyVector(unknownOps[i], fmtMfc, funSll, stLvl, noInt);
		end
		finishTest("alu classes and unknown codes");

		for (int k = 0; k < 5; k++)
		begin
			applyVector(opRFmt, fmtMfc, funAdd, trapSt[k], trapPend[k]);
			applyVector(opRFmt, fmtMfc, funSub, trapSt[k], trapPend[k]);
			applyVector(opAddi, fmtMfc, funSll, trapSt[k], trapPend[k]);
			applyVector(opRFmt, fmtMfc, funMovz, trapSt[k] | stEz, trapPend[k]);
			applyVector(opRFmt, fmtMfc, funMovn, trapSt[k], trapPend[k]);
		end
		for (int i = 0; i < 2; i++)
		begin
			applyVector(opLw, fmtMfc, funSll, (i == 1) ? stLvl : stNone, oneInt);
			applyVector(opBeq, fmtMfc, funSll, (i == 1) ? stLvl : stNone, oneInt);
			applyVector(opLui, fmtMfc, funSll, (i == 1) ? stLvl : stNone, oneInt);
			applyVector(opOri, fmtMfc, funSll, (i == 1) ? stLvl : stNone, oneInt);
			applyVector(opRFmt, fmtMfc, funAnd, (i == 1) ? stLvl : stNone, oneInt);
			applyVector(opRFmt, fmtMfc, funSyscall, (i == 1) ? stLvl : stNone, noInt);
		end
		finishTest("exceptions");

		for (int u = 0; u < 2; u++)
		begin
			applyVector(opCop0, fmtMfc, funSll, (u == 1) ? stUser : stNone, noInt);
			applyVector(opCop0, fmtMtc, funSll, (u == 1) ? stUser : stNone, noInt);
			applyVector(opCop0, fmtEret, funEret, (u == 1) ? stUser : stNone, noInt);
			applyVector(opCop0, fmtEret, funSll, (u == 1) ? stUser : stNone, noInt);
			applyVector(opCop0, 5'h08, funSll, (u == 1) ? stUser : stNone, noInt);
			applyVector(opCop0, fmtMfc, funSll, ((u == 1) ? stUser : stNone) | stLvl, oneInt);
			applyVector(opCop0, fmtEret, funEret, ((u == 1) ? stUser : stNone) | stLvl, oneInt);
		end
		finishTest("cop0 privilege");

		// half the opcodes come from the kept set so fewer land on invalid
		for (int i = 0; i < RandomVectors; i++)
		begin
			r = $random(seed);
			s = $random(seed);
			applyVector(s[4] ? keptOps[s[3:0]] : r[31:26],
				s[5] ? fmtPicks[s[7:6]] : r[25:21],
				s[16] ? funEret : r[5:0],
				{s[8], s[9], s[10] & s[11], s[12]},
				(s[15:13] == 3'd0) ? NumInterrupts'(s[31:17]) : noInt);
		end
		finishTest("random sweep");

		$display("%0d tests run, %0d vectors compared, %0d errors", testCount, checkCount,
			errorCount);
		if (errorCount == 0 && checkCount > 0)
			$display("all tests passed");
		else
		begin
			if (checkCount == 0)
				$display("no outputs were compared");
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: mipsControl.f
source/mipsControlPkg.sv
source/instrDecoder.sv
source/datapathControl.sv
source/exceptionControl.sv
source/mipsControl.sv
testbench/controlChecker.sv
testbench/mipsControlTb.sv

// File: Makefile
# Verilator build for the MIPS control unit testbench

VERILATOR ?= verilator
TOP ?= mipsControlTb
FILELIST ?= mipsControl.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0
PASS_MSG ?= all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run passes only when the pass message shows up as a line of its own
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
